//--- verification/decode_vectors.txt
// instr compat controls, controls from bit 26 down: masked store logic sel[3] move sx xs vy
// add sel[2] widen mm mm_sel cmp cmp_sel[3] mul sel[2] sll sr signed0 signed1
5E20C1D7 1 01F20000 // vmv.v.x
5C20C1D7 0 00000000 // vmerge, not a move
422021D7 1 01F40000 // vmv.x.s
4200E1D7 1 01F80000 // vmv.s.x
262081D7 3 01200000 // vand.vv
242081D7 3 05200000 // vand.vv masked
2A20C1D7 3 01400000 // vor.vx
2E20B1D7 3 01600000 // vxor.vi
0A2081D7 3 00014000 // vsub.vv
0E20C1D7 3 00014002 // vrsub.vx
CA20A1D7 3 00016000 // vwsubu.vv
CE20E1D7 3 00016003 // vwsub.vx
1E2081D7 1 00011802 // vmax.vv
1220C1D7 1 00011000 // vminu.vx
6E20C1D7 1 00018602 // vmslt.vx
9E20A1D7 1 00000053 // vmulh.vv
EE20E1D7 1 00002043 // vwmul.vx
EA20A1D7 1 00002052 // vwmulsu.vv
9620B1D7 1 00000068 // vsll.vi
A620C1D7 1 00000074 // vsra.vx
0202E227 3 02000000 // vse32.v unit stride
0002E227 3 06000000 // vse32.v masked
0A02E227 0 00000000 // vsse32.v strided

//--- vlog.f
verilog/rvv_pkg.sv
verilog/valu_logic_move_decode.sv
verilog/valu_add_decode.sv
verilog/valu_mulshift_decode.sv
verilog/valu_issue_stage.sv
verilog/valu_compat_check.sv
verilog/rvv_issue_decoder.sv
verification/rvv_issue_decoder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary -f vlog.f --top-module rvv_issue_decoder_tb &&
sim_out="$(./obj_dir/Vrvv_issue_decoder_tb)" ||
{ echo "$sim_out"; echo "Build or simulation run did not complete"; exit 1; }
echo "$sim_out"
echo "$sim_out" | grep -q "SIMULATION PASSED" || exit 1

//--- verification/rvv_issue_decoder_tb.sv
`timescale 1ns/1ns

module rvv_issue_decoder_tb;

    localparam int         NUM_VEC         = 23;
    localparam int         NUM_RAND        = 32;
    localparam int         WATCHDOG_CYCLES = 3 * NUM_VEC + NUM_RAND + 20;
    localparam logic [6:0] OPC_SCALAR_OP   = 7'b0110011;

    logic             clk = 1'b0;
    logic             rst_n;
    rvv_pkg::vinstr_t instr;
    logic             instr_valid;
    logic             ctrl_valid;
    logic             masked;
    logic             store_en;
    logic             logic_en;
    logic [2:0]       logic_op_sel;
    logic             move_en;
    logic             move_sx;
    logic             move_xs;
    logic             move_vy;
    logic             add_en;
    logic [1:0]       add_op_sel;
    logic             widen_en;
    logic             min_max_en;
    logic             min_max_op_sel;
    logic             cmp_en;
    logic [2:0]       cmp_op_sel;
    logic             mul_en;
    logic [1:0]       mul_op_sel;
    logic             shift_left;
    logic             shift_right;
    logic             signed_op0;
    logic             signed_op1;
    logic [1:0]       alu_compatible;

    logic [31:0] vec_mem [0:3*NUM_VEC-1]; // instr, compat, controls per vector
    logic [26:0] act_ctrl;
    logic [31:0] lfsr_state;
    logic [31:0] rand_word;
    int          check_count;
    int          error_count;

    // Result expected at the next falling edge
    logic        pend_valid;
    logic [31:0] pend_compat;
    logic [31:0] pend_ctrl;
    string       pend_name;

    rvv_issue_decoder rvv_issue_decoder_i (.*);

    always #5 clk = ~clk;

    // Same order as the controls column of the vector file
    assign act_ctrl = {masked, store_en, logic_en, logic_op_sel, move_en, move_sx, move_xs,
                       move_vy, add_en, add_op_sel, widen_en, min_max_en, min_max_op_sel,
                       cmp_en, cmp_op_sel, mul_en, mul_op_sel, shift_left, shift_right,
                       signed_op0, signed_op1};

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
        end
        return next;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        compare({pend_name, " ctrl_valid"}, {31'd0, pend_valid}, {31'd0, ctrl_valid});
        compare({pend_name, " alu_compatible"}, pend_compat, {30'd0, alu_compatible});
        compare({pend_name, " controls"}, pend_ctrl, {5'd0, act_ctrl});
    endtask

    // Checks the cycle before, then drives the next one
    task automatic clock_in(input logic valid, input logic [31:0] word,
                            input logic [31:0] exp_compat, input logic [31:0] exp_ctrl,
                            input string name);
        @(negedge clk);
        check_outputs();
        instr       = word;
        instr_valid = valid;
        pend_valid  = valid;
        pend_compat = valid ? exp_compat : 32'd0;
        pend_ctrl   = valid ? exp_ctrl : 32'd0;
        pend_name   = valid ? name : {"idle after ", name};
    endtask

    task automatic make_scalar_instr(output logic [31:0] word);
        word = {25'd0, OPC_SCALAR_OP};
        for (int b = 7; b < 32; b++) begin
            word[b]    = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Watchdog expired before the testbench finished its sequence");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        lfsr_state  = 32'd23;
        check_count = 0;
        error_count = 0;
        pend_valid  = 1'b0;
        pend_compat = 32'd0;
        pend_ctrl   = 32'd0;
        pend_name   = "during reset";
        $readmemh("verification/decode_vectors.txt", vec_mem);
        // A strobe held through reset must not reach the outputs
        instr       = vec_mem[0];
        instr_valid = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_outputs();
        rst_n       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        pend_name   = "after reset";
        clock_in(1'b0, 32'd0, 32'd0, 32'd0, "reset");

        // Isolated strobes, one idle cycle after each
        for (int i = 0; i < NUM_VEC; i++) begin
            clock_in(1'b1, vec_mem[3*i], vec_mem[3*i+1], vec_mem[3*i+2],
                     $sformatf("vector %0d", i));
            clock_in(1'b0, 32'd0, 32'd0, 32'd0, $sformatf("vector %0d", i));
        end

        // Back-to-back strobes
        for (int i = 0; i < NUM_VEC; i++) begin
            clock_in(1'b1, vec_mem[3*i], vec_mem[3*i+1], vec_mem[3*i+2],
                     $sformatf("stream vector %0d", i));
        end
        clock_in(1'b0, 32'd0, 32'd0, 32'd0, "stream");

        // Scalar OP words decode to nothing
        for (int i = 0; i < NUM_RAND; i++) begin
            make_scalar_instr(rand_word);
            clock_in(1'b1, rand_word, 32'd0, 32'd0, $sformatf("random %0d", i));
        end
        clock_in(1'b0, 32'd0, 32'd0, 32'd0, "random");
        clock_in(1'b0, 32'd0, 32'd0, 32'd0, "end");

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/rvv_issue_decoder.sv
`timescale 1ns/1ns

module rvv_issue_decoder #(
    parameter int                   ALU_COUNT       = 2,
    // ALU0 has every unit, ALU1 only logic and add
    parameter logic [ALU_COUNT-1:0] AND_OR_XOR_MASK = 2'b11,
    parameter logic [ALU_COUNT-1:0] MOVE_MASK       = 2'b01,
    parameter logic [ALU_COUNT-1:0] ADD_SUB_MASK    = 2'b11,
    parameter logic [ALU_COUNT-1:0] MIN_MAX_MASK    = 2'b01,
    parameter logic [ALU_COUNT-1:0] CMP_MASK        = 2'b01,
    parameter logic [ALU_COUNT-1:0] MULT_MASK       = 2'b01,
    parameter logic [ALU_COUNT-1:0] SHIFT_MASK      = 2'b01
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rvv_pkg::vinstr_t     instr,
    input  logic                 instr_valid,
    output logic                 ctrl_valid,
    output logic                 masked,
    output logic                 store_en,
    output logic                 logic_en,
    output logic [2:0]           logic_op_sel,
    output logic                 move_en,
    output logic                 move_sx,
    output logic                 move_xs,
    output logic                 move_vy,
    output logic                 add_en,
    output logic [1:0]           add_op_sel,
    output logic                 widen_en,
    output logic                 min_max_en,
    output logic                 min_max_op_sel,
    output logic                 cmp_en,
    output logic [2:0]           cmp_op_sel,
    output logic                 mul_en,
    output logic [1:0]           mul_op_sel,
    output logic                 shift_left,
    output logic                 shift_right,
    output logic                 signed_op0,
    output logic                 signed_op1,
    output logic [ALU_COUNT-1:0] alu_compatible
);

    // Combinational group decodes
    logic       dec_logic_en;
    logic [2:0] dec_logic_op_sel;
    logic       dec_move_sx;
    logic       dec_move_xs;
    logic       dec_move_vy;
    logic       dec_add_en;
    logic [1:0] dec_add_op_sel;
    logic       dec_widen_add;
    logic       dec_min_max_en;
    logic       dec_min_max_op_sel;
    logic       dec_cmp_en;
    logic [2:0] dec_cmp_op_sel;
    logic       dec_add_signed_op0;
    logic       dec_add_signed_op1;
    logic       dec_mul_en;
    logic [1:0] dec_mul_op_sel;
    logic       dec_shift_left;
    logic       dec_shift_right;
    logic       dec_widen_mul;
    logic       dec_mul_signed_op0;
    logic       dec_mul_signed_op1;

    valu_logic_move_decode #(
        .MOVE_EN      (|MOVE_MASK),
        .AND_OR_XOR_EN(|AND_OR_XOR_MASK)
    ) u_logic_move (
        .instr       (instr),
        .logic_en    (dec_logic_en),
        .logic_op_sel(dec_logic_op_sel),
        .move_sx     (dec_move_sx),
        .move_xs     (dec_move_xs),
        .move_vy     (dec_move_vy)
    );

    valu_add_decode #(
        .ADD_SUB_EN(|ADD_SUB_MASK),
        .MIN_MAX_EN(|MIN_MAX_MASK),
        .CMP_EN    (|CMP_MASK)
    ) u_add (
        .instr         (instr),
        .add_en        (dec_add_en),
        .add_op_sel    (dec_add_op_sel),
        .widen_add     (dec_widen_add),
        .min_max_en    (dec_min_max_en),
        .min_max_op_sel(dec_min_max_op_sel),
        .cmp_en        (dec_cmp_en),
        .cmp_op_sel    (dec_cmp_op_sel),
        .add_signed_op0(dec_add_signed_op0),
        .add_signed_op1(dec_add_signed_op1)
    );

    valu_mulshift_decode #(
        .MULT_EN (|MULT_MASK),
        .SHIFT_EN(|SHIFT_MASK)
    ) u_mulshift (
        .instr         (instr),
        .mul_en        (dec_mul_en),
        .mul_op_sel    (dec_mul_op_sel),
        .shift_left    (dec_shift_left),
        .shift_right   (dec_shift_right),
        .widen_mul     (dec_widen_mul),
        .mul_signed_op0(dec_mul_signed_op0),
        .mul_signed_op1(dec_mul_signed_op1)
    );

    // Port names match the dec_* wires and the top outputs
    valu_issue_stage u_issue (.*);

    valu_compat_check #(
        .ALU_COUNT      (ALU_COUNT),
        .AND_OR_XOR_MASK(AND_OR_XOR_MASK),
        .MOVE_MASK      (MOVE_MASK),
        .ADD_SUB_MASK   (ADD_SUB_MASK),
        .MIN_MAX_MASK   (MIN_MAX_MASK),
        .CMP_MASK       (CMP_MASK),
        .MULT_MASK      (MULT_MASK),
        .SHIFT_MASK     (SHIFT_MASK)
    ) u_compat (.*);

endmodule

//--- verilog/valu_compat_check.sv
`timescale 1ns/1ns

module valu_compat_check #(
    parameter int                   ALU_COUNT       = 2,
    parameter logic [ALU_COUNT-1:0] AND_OR_XOR_MASK = '1,
    parameter logic [ALU_COUNT-1:0] MOVE_MASK       = '1,
    parameter logic [ALU_COUNT-1:0] ADD_SUB_MASK    = '1,
    parameter logic [ALU_COUNT-1:0] MIN_MAX_MASK    = '1,
    parameter logic [ALU_COUNT-1:0] CMP_MASK        = '1,
    parameter logic [ALU_COUNT-1:0] MULT_MASK       = '1,
    parameter logic [ALU_COUNT-1:0] SHIFT_MASK      = '1
) (
    input  logic                 logic_en,
    input  logic                 move_en,
    input  logic                 add_en,
    input  logic                 min_max_en,
    input  logic                 cmp_en,
    input  logic                 mul_en,
    input  logic                 shift_left,
    input  logic                 shift_right,
    input  logic                 store_en,
    output logic [ALU_COUNT-1:0] alu_compatible
);

    logic any_shift;
    logic plain_add;

    assign any_shift = shift_left | shift_right;
    assign plain_add = add_en & ~(min_max_en | cmp_en);

    for (genvar i = 0; i < ALU_COUNT; i++) begin : g_alu
        assign alu_compatible[i] =
            (MOVE_MASK[i] & AND_OR_XOR_MASK[i] & move_en) |   // Move runs on the logic unit
            (AND_OR_XOR_MASK[i] & logic_en & ~move_en) |
            (ADD_SUB_MASK[i] & plain_add) |
            (ADD_SUB_MASK[i] & MIN_MAX_MASK[i] & min_max_en) |
            (ADD_SUB_MASK[i] & CMP_MASK[i] & cmp_en) |
            (MULT_MASK[i] & mul_en & ~any_shift) |
            (SHIFT_MASK[i] & any_shift) |
            store_en;                                         // Any ALU can issue a store
    end

endmodule

//--- verilog/valu_issue_stage.sv
`timescale 1ns/1ns

module valu_issue_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  rvv_pkg::vinstr_t instr,
    input  logic             instr_valid,
    input  logic             dec_logic_en,
    input  logic [2:0]       dec_logic_op_sel,
    input  logic             dec_move_sx,
    input  logic             dec_move_xs,
    input  logic             dec_move_vy,
    input  logic             dec_add_en,
    input  logic [1:0]       dec_add_op_sel,
    input  logic             dec_widen_add,
    input  logic             dec_min_max_en,
    input  logic             dec_min_max_op_sel,
    input  logic             dec_cmp_en,
    input  logic [2:0]       dec_cmp_op_sel,
    input  logic             dec_add_signed_op0,
    input  logic             dec_add_signed_op1,
    input  logic             dec_mul_en,
    input  logic [1:0]       dec_mul_op_sel,
    input  logic             dec_shift_left,
    input  logic             dec_shift_right,
    input  logic             dec_widen_mul,
    input  logic             dec_mul_signed_op0,
    input  logic             dec_mul_signed_op1,
    output logic             ctrl_valid,
    output logic             masked,
    output logic             store_en,
    output logic             logic_en,
    output logic [2:0]       logic_op_sel,
    output logic             move_en,
    output logic             move_sx,
    output logic             move_xs,
    output logic             move_vy,
    output logic             add_en,
    output logic [1:0]       add_op_sel,
    output logic             widen_en,
    output logic             min_max_en,
    output logic             min_max_op_sel,
    output logic             cmp_en,
    output logic [2:0]       cmp_op_sel,
    output logic             mul_en,
    output logic [1:0]       mul_op_sel,
    output logic             shift_left,
    output logic             shift_right,
    output logic             signed_op0,
    output logic             signed_op1
);

    localparam int CTRL_W = 27;

    logic              store_dec;
    logic              move_any;
    logic              vec_op;
    logic [CTRL_W-1:0] ctrl_d;
    logic [CTRL_W-1:0] ctrl_q;

    // Unit-stride vector store
    assign store_dec = (instr.store.opcode == rvv_pkg::OPC_STORE_FP) && (instr.store.mop == 2'b00);
    assign move_any  = dec_move_sx | dec_move_xs | dec_move_vy;
    assign vec_op    = dec_logic_en | move_any | dec_add_en | dec_mul_en | store_dec;

    assign ctrl_d = {
        vec_op & ~instr.arith.vm,
        store_dec,
        dec_logic_en, dec_logic_op_sel,
        move_any, dec_move_sx, dec_move_xs, dec_move_vy,
        dec_add_en, dec_add_op_sel,
        dec_widen_add | dec_widen_mul,
        dec_min_max_en, dec_min_max_op_sel,
        dec_cmp_en, dec_cmp_op_sel,
        dec_mul_en, dec_mul_op_sel,
        dec_shift_left, dec_shift_right,
        dec_add_en ? dec_add_signed_op0 : dec_mul_signed_op0,  // Only one path claims an op
        dec_add_en ? dec_add_signed_op1 : dec_mul_signed_op1
    };

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_valid <= 1'b0;
            ctrl_q     <= '0;
        end else begin
            ctrl_valid <= instr_valid;
            ctrl_q     <= instr_valid ? ctrl_d : '0; // Idle between strobes
        end
    end

    assign {masked, store_en, logic_en, logic_op_sel, move_en, move_sx, move_xs, move_vy,
            add_en, add_op_sel, widen_en, min_max_en, min_max_op_sel, cmp_en, cmp_op_sel,
            mul_en, mul_op_sel, shift_left, shift_right, signed_op0, signed_op1} = ctrl_q;

endmodule

//--- verilog/valu_mulshift_decode.sv
`timescale 1ns/1ns

module valu_mulshift_decode #(
    parameter bit MULT_EN  = 1'b1,
    parameter bit SHIFT_EN = 1'b1
) (
    input  rvv_pkg::vinstr_t instr,
    output logic             mul_en,
    output logic [1:0]       mul_op_sel,
    output logic             shift_left,
    output logic             shift_right,
    output logic             widen_mul,
    output logic             mul_signed_op0,
    output logic             mul_signed_op1
);

    logic       is_opv;
    logic       opi;
    logic       opm;
    logic       mul_op;
    logic       shl_op;
    logic       shr_op;
    logic [5:0] funct6;
    logic [2:0] funct3;

    assign is_opv = (instr.arith.opcode == rvv_pkg::OPC_OP_V);
    assign funct6 = instr.arith.funct6;
    assign funct3 = instr.arith.funct3;
    assign opi    = funct3 inside {rvv_pkg::F3_OPIVV, rvv_pkg::F3_OPIVX, rvv_pkg::F3_OPIVI};
    assign opm    = funct3 inside {rvv_pkg::F3_OPMVV, rvv_pkg::F3_OPMVX};

    // vsll and vmul share funct6, funct3 keeps them apart
    assign shl_op = SHIFT_EN && is_opv && opi && (funct6 == rvv_pkg::F6_VSLL);
    assign shr_op = SHIFT_EN && is_opv && opi &&
                    funct6 inside {rvv_pkg::F6_VSRL, rvv_pkg::F6_VSRA};
    assign mul_op = MULT_EN && is_opv && opm &&
                    funct6 inside {rvv_pkg::F6_VMUL, rvv_pkg::F6_VMULH,
                                   rvv_pkg::F6_VWMUL, rvv_pkg::F6_VWMULSU};

    always_comb begin
        mul_en         = shl_op | shr_op | mul_op;
        mul_op_sel     = rvv_pkg::MULSHIFT_SEL_MUL_LOW;
        shift_left     = shl_op;
        shift_right    = shr_op;
        widen_mul      = 1'b0;
        mul_signed_op0 = 1'b0;
        mul_signed_op1 = 1'b0;
        if (shl_op) begin
            mul_op_sel = rvv_pkg::MULSHIFT_SEL_SLL;
        end else if (shr_op) begin
            mul_op_sel = rvv_pkg::MULSHIFT_SEL_SR; // Logical vs arithmetic left to the unit
        end else if (mul_op) begin
            widen_mul = funct6 inside {rvv_pkg::F6_VWMUL, rvv_pkg::F6_VWMULSU};
            if (funct6 inside {rvv_pkg::F6_VMULH, rvv_pkg::F6_VWMULSU}) begin
                mul_op_sel = rvv_pkg::MULSHIFT_SEL_MUL_HIGH;
            end
            mul_signed_op0 = 1'b1;
            if (funct6 inside {rvv_pkg::F6_VMULH, rvv_pkg::F6_VWMUL}) begin
                mul_signed_op1 = 1'b1;
            end else if (funct6 == rvv_pkg::F6_VMUL) begin
                mul_signed_op1 = (funct6[3] & funct6[1]) | funct6[0];
            end
        end
    end

endmodule

//--- verilog/valu_add_decode.sv
`timescale 1ns/1ns

module valu_add_decode #(
    parameter bit ADD_SUB_EN = 1'b1,
    parameter bit MIN_MAX_EN = 1'b1,
    parameter bit CMP_EN     = 1'b1
) (
    input  rvv_pkg::vinstr_t instr,
    output logic             add_en,
    output logic [1:0]       add_op_sel,
    output logic             widen_add,
    output logic             min_max_en,
    output logic             min_max_op_sel,
    output logic             cmp_en,
    output logic [2:0]       cmp_op_sel,
    output logic             add_signed_op0,
    output logic             add_signed_op1
);

    logic       path_on;
    logic       opi;
    logic       ivvx;     // VV or VX only
    logic       opm;
    logic       plain_op;
    logic       widen_op;
    logic       mm_op;
    logic       cmp_op;
    logic [5:0] funct6;
    logic [2:0] funct3;

    assign path_on = ADD_SUB_EN && (instr.arith.opcode == rvv_pkg::OPC_OP_V);
    assign funct6  = instr.arith.funct6;
    assign funct3  = instr.arith.funct3;
    assign ivvx    = funct3 inside {rvv_pkg::F3_OPIVV, rvv_pkg::F3_OPIVX};
    assign opi     = ivvx || (funct3 == rvv_pkg::F3_OPIVI);
    assign opm     = funct3 inside {rvv_pkg::F3_OPMVV, rvv_pkg::F3_OPMVX};

    // vsub has no immediate form, vrsub no vector-vector form
    assign plain_op = path_on && opi &&
                      ((funct6 == rvv_pkg::F6_VADD) ||
                       (funct6 == rvv_pkg::F6_VSUB && funct3 != rvv_pkg::F3_OPIVI) ||
                       (funct6 == rvv_pkg::F6_VRSUB && funct3 != rvv_pkg::F3_OPIVV));
    assign widen_op = path_on && opm &&
                      funct6 inside {rvv_pkg::F6_VWADDU, rvv_pkg::F6_VWADD,
                                     rvv_pkg::F6_VWSUBU, rvv_pkg::F6_VWSUB};
    assign mm_op    = path_on && MIN_MAX_EN && ivvx &&
                      funct6 inside {rvv_pkg::F6_VMINU, rvv_pkg::F6_VMIN,
                                     rvv_pkg::F6_VMAXU, rvv_pkg::F6_VMAX};
    assign cmp_op   = path_on && CMP_EN && opi &&
                      (funct6[5:3] == 3'b011) &&  // vmseq through vmsgt
                      !(funct6 inside {rvv_pkg::F6_VMSLTU, rvv_pkg::F6_VMSLT} &&
                        funct3 == rvv_pkg::F3_OPIVI) &&
                      !(funct6 inside {rvv_pkg::F6_VMSGTU, rvv_pkg::F6_VMSGT} &&
                        funct3 == rvv_pkg::F3_OPIVV);

    always_comb begin
        add_en         = 1'b0;
        add_op_sel     = rvv_pkg::ADD_SEL_ADD;
        widen_add      = 1'b0;
        min_max_en     = 1'b0;
        min_max_op_sel = 1'b0;
        cmp_en         = 1'b0;
        cmp_op_sel     = 3'b000;
        add_signed_op0 = 1'b0;
        add_signed_op1 = 1'b0;
        if (plain_op || widen_op) begin
            add_en    = 1'b1;
            widen_add = widen_op;
            if (funct6 inside {rvv_pkg::F6_VSUB, rvv_pkg::F6_VRSUB,
                               rvv_pkg::F6_VWSUBU, rvv_pkg::F6_VWSUB}) begin
                add_op_sel = rvv_pkg::ADD_SEL_SUB;
            end
            if (widen_op) begin // Signed widening forms sign-extend both sources
                add_signed_op0 = funct6 inside {rvv_pkg::F6_VWADD, rvv_pkg::F6_VWSUB};
                add_signed_op1 = add_signed_op0;
            end else begin
                add_signed_op0 = funct6[0];
            end
        end else if (mm_op) begin
            add_en         = 1'b1;
            min_max_en     = 1'b1;
            min_max_op_sel = funct6[1]; // 1 selects max
            add_signed_op0 = funct6 inside {rvv_pkg::F6_VMIN, rvv_pkg::F6_VMAX};
        end else if (cmp_op) begin
            add_en         = 1'b1;
            cmp_en         = 1'b1;
            add_op_sel     = rvv_pkg::ADD_SEL_CMP;
            cmp_op_sel     = funct3;
            add_signed_op0 = funct6 inside {rvv_pkg::F6_VMSLE, rvv_pkg::F6_VMSLT,
                                            rvv_pkg::F6_VMSGT};
        end
    end

endmodule

//--- verilog/valu_logic_move_decode.sv
`timescale 1ns/1ns

module valu_logic_move_decode #(
    parameter bit MOVE_EN       = 1'b1,
    parameter bit AND_OR_XOR_EN = 1'b1
) (
    input  rvv_pkg::vinstr_t instr,
    output logic             logic_en,
    output logic [2:0]       logic_op_sel,
    output logic             move_sx,
    output logic             move_xs,
    output logic             move_vy
);

    logic       is_opv;
    logic       opi;      // VV, VX or VI integer form
    logic       is_move;
    logic [5:0] funct6;
    logic [2:0] funct3;

    assign is_opv = (instr.arith.opcode == rvv_pkg::OPC_OP_V);
    assign funct6 = instr.arith.funct6;
    assign funct3 = instr.arith.funct3;
    assign opi    = funct3 inside {rvv_pkg::F3_OPIVV, rvv_pkg::F3_OPIVX, rvv_pkg::F3_OPIVI};

    always_comb begin
        move_sx = 1'b0;
        move_xs = 1'b0;
        move_vy = 1'b0;
        if (MOVE_EN && is_opv) begin
            // Scalar moves share funct6 and leave one source field zero
            move_sx = (funct6 == rvv_pkg::F6_VWXUNARY0) && (funct3 == rvv_pkg::F3_OPMVX)
                      && (instr.arith.vs2 == 5'd0);
            move_xs = (funct6 == rvv_pkg::F6_VWXUNARY0) && (funct3 == rvv_pkg::F3_OPMVV)
                      && (instr.arith.vs1 == 5'd0);
            move_vy = (funct6 == rvv_pkg::F6_VMV) && opi && instr.arith.vm;
        end
    end

    assign is_move = move_sx | move_xs | move_vy;

    always_comb begin
        logic_en     = 1'b0;
        logic_op_sel = 3'b000;
        if (AND_OR_XOR_EN) begin
            if (is_move) begin // Moves run through the logic unit
                logic_en     = 1'b1;
                logic_op_sel = rvv_pkg::AOR_SEL_MOV;
            end else if (is_opv && opi &&
                         funct6 inside {rvv_pkg::F6_VAND, rvv_pkg::F6_VOR, rvv_pkg::F6_VXOR}) begin
                logic_en     = 1'b1;
                logic_op_sel = funct6[2:0];
            end
        end
    end

endmodule

//--- verilog/rvv_pkg.sv
package rvv_pkg;

    localparam int INSTR_WIDTH = 32;

    // Major opcodes
    localparam logic [6:0] OPC_OP_V     = 7'b1010111;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

    // Operand categories
    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPMVV = 3'b010;
    localparam logic [2:0] F3_OPIVI = 3'b011;
    localparam logic [2:0] F3_OPIVX = 3'b100;
    localparam logic [2:0] F3_OPMVX = 3'b110;

    // Integer forms under OPIVV/OPIVX/OPIVI
    localparam logic [5:0] F6_VADD    = 6'b000000;
    localparam logic [5:0] F6_VSUB    = 6'b000010;
    localparam logic [5:0] F6_VRSUB   = 6'b000011;
    localparam logic [5:0] F6_VMINU   = 6'b000100;
    localparam logic [5:0] F6_VMIN    = 6'b000101;
    localparam logic [5:0] F6_VMAXU   = 6'b000110;
    localparam logic [5:0] F6_VMAX    = 6'b000111;
    localparam logic [5:0] F6_VAND    = 6'b001001;
    localparam logic [5:0] F6_VOR     = 6'b001010;
    localparam logic [5:0] F6_VXOR    = 6'b001011;
    localparam logic [5:0] F6_VMV     = 6'b010111; // vmerge when vm is 0
    localparam logic [5:0] F6_VMSEQ   = 6'b011000;
    localparam logic [5:0] F6_VMSNE   = 6'b011001;
    localparam logic [5:0] F6_VMSLTU  = 6'b011010;
    localparam logic [5:0] F6_VMSLT   = 6'b011011;
    localparam logic [5:0] F6_VMSLEU  = 6'b011100;
    localparam logic [5:0] F6_VMSLE   = 6'b011101;
    localparam logic [5:0] F6_VMSGTU  = 6'b011110;
    localparam logic [5:0] F6_VMSGT   = 6'b011111;
    localparam logic [5:0] F6_VSLL    = 6'b100101;
    localparam logic [5:0] F6_VSRL    = 6'b101000;
    localparam logic [5:0] F6_VSRA    = 6'b101001;

    // Forms under OPMVV/OPMVX
    localparam logic [5:0] F6_VWXUNARY0 = 6'b010000; // vmv.x.s and vmv.s.x
    localparam logic [5:0] F6_VMUL      = 6'b100101;
    localparam logic [5:0] F6_VMULH     = 6'b100111;
    localparam logic [5:0] F6_VWADDU    = 6'b110000;
    localparam logic [5:0] F6_VWADD     = 6'b110001;
    localparam logic [5:0] F6_VWSUBU    = 6'b110010;
    localparam logic [5:0] F6_VWSUB     = 6'b110011;
    localparam logic [5:0] F6_VWMULSU   = 6'b111010;
    localparam logic [5:0] F6_VWMUL     = 6'b111011;

    // Unit selects
    localparam logic [2:0] AOR_SEL_MOV           = 3'b111;
    localparam logic [1:0] ADD_SEL_ADD           = 2'b00;
    localparam logic [1:0] ADD_SEL_SUB           = 2'b01;
    localparam logic [1:0] ADD_SEL_CMP           = 2'b10;
    localparam logic [1:0] MULSHIFT_SEL_MUL_LOW  = 2'b00;
    localparam logic [1:0] MULSHIFT_SEL_MUL_HIGH = 2'b01;
    localparam logic [1:0] MULSHIFT_SEL_SLL      = 2'b10;
    localparam logic [1:0] MULSHIFT_SEL_SR       = 2'b11;

    // One instruction word, read as OP-V arithmetic or as a vector store
    typedef union packed {
        struct packed {
            logic [5:0] funct6;
            logic       vm;
            logic [4:0] vs2;
            logic [4:0] vs1;
            logic [2:0] funct3;
            logic [4:0] vd;
            logic [6:0] opcode;
        } arith;
        struct packed {
            logic [2:0] nf;
            logic       mew;
            logic [1:0] mop;    // 0 is unit stride
            logic       vm;
            logic [4:0] sumop;
            logic [4:0] rs1;
            logic [2:0] width;
            logic [4:0] vs3;
            logic [6:0] opcode;
        } store;
    } vinstr_t;

endpackage
